// File: flist.f
src/snac_pkg.sv
src/snac_strobe_gen.sv
src/snac_serlatch_poller.sv
src/snac_pin_router.sv
src/snac_top.sv
dv/snac_pad_model.sv
dv/snac_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module snac_tb -f flist.f -o snac_sim

out="$(./obj_dir/snac_sim)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// File: dv/snac_tb.sv
// Testbench top with clock, reset, pad model, directed tests and result report
`timescale 1ns/1ps

module snac_tb import snac_pkg::*; ();

    localparam int FRAME_TIMEOUT = 5000;     // Cycles allowed per wait

    logic              clk;
    logic              rst_n;
    logic              conf_ab;
    logic [4:0]        cont_type;
    logic [RATE_W-1:0] rate;
    logic [BTN_W-1:0]  p1_btn;
    logic [BTN_W-1:0]  p2_btn;
    logic              busy;
    logic              bk0_dir;
    logic [3:0]        bk0_in;
    logic [1:0]        bk1_out;
    logic              pin30_out;
    logic              pin30_dir;
    logic              pin31_out;
    logic              pin31_dir;
    logic              pad_dat1;
    logic              pad_dat2;
    logic [15:0]       pat1;
    logic [15:0]       pat2;
    int                seed;
    int                test_errs;
    int                errors;
    int                tests_run;
    int                tests_failed;

    assign bk0_in = {2'b11, pad_dat2, pad_dat1};   // Bits 7:6 unused and pulled high

    snac_top snac_top_i (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_conf_ab        (conf_ab),
        .i_game_cont_type (cont_type),
        .i_sample_rate    (rate),
        .o_p1_btn         (p1_btn),
        .o_p2_btn         (p2_btn),
        .o_busy           (busy),
        .o_cart_bk0_dir   (bk0_dir),
        .i_cart_bk0_in    (bk0_in),
        .o_cart_bk1_out   (bk1_out),
        .o_cart_pin30_out (pin30_out),
        .o_cart_pin30_dir (pin30_dir),
        .i_cart_pin30_in  (1'b0),
        .o_cart_pin31_out (pin31_out),
        .o_cart_pin31_dir (pin31_dir),
        .i_cart_pin31_in  (1'b1)
    );

    // Latch on bank1 bit 7, clock on bit 6, second clock on pin30
    snac_pad_model u_pads (
        .i_lat  (bk1_out[1]),
        .i_clk1 (bk1_out[0]),
        .i_clk2 (pin30_out),
        .i_pat1 (pat1),
        .i_pat2 (pat2),
        .o_dat1 (pad_dat1),
        .o_dat2 (pad_dat2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic apply_settings(input logic conf, input gc_type_e t,
                                  input logic [RATE_W-1:0] r);
        @(negedge clk);
        conf_ab   = conf;
        cont_type = t;
        rate      = r;
    endtask

    task automatic roll_patterns();
        pat1 = 16'($random(seed));
        pat2 = 16'($random(seed));
    endtask

    task automatic check_eq(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    // Counts falling edges of o_busy as frame ends
    task automatic wait_busy_falls(input int n);
        int   falls;
        int   cyc;
        logic prev;
        falls = 0;
        cyc   = 0;
        prev  = busy;
        while (falls < n && cyc < FRAME_TIMEOUT * n) begin
            @(negedge clk);
            cyc++;
            if (prev && !busy) falls++;
            prev = busy;
        end
        if (falls < n) begin
            $display("Timeout at t=%0t, saw %0d of %0d frame ends", $time, falls, n);
            test_errs++;
        end
    endtask

    task automatic wait_busy_rise();
        int cyc;
        cyc = 0;
        while (!busy && cyc < FRAME_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!busy) begin
            $display("Timeout at t=%0t, no frame started", $time);
            test_errs++;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, test_errs);
            tests_failed++;
        end
        errors    += test_errs;
        test_errs = 0;
    endtask

    task automatic check_reset_state();
        logic rose;
        rose = 1'b0;
        check_eq("o_p1_btn", p1_btn, 16'h0);
        check_eq("o_p2_btn", p2_btn, 16'h0);
        check_eq("o_busy", 16'(busy), 16'h0);
        check_eq("o_cart_bk1_out", 16'(bk1_out), 16'h0);
        check_eq("o_cart_bk0_dir", 16'(bk0_dir), 16'h0);
        check_eq("o_cart_pin30_dir", 16'(pin30_dir), 16'h1);
        check_eq("o_cart_pin31_dir", 16'(pin31_dir), 16'h0);
        repeat (2000) begin
            @(negedge clk);
            if (busy) rose = 1'b1;
        end
        if (rose) begin
            $display("o_busy rose while the controller type was disabled");
            test_errs++;
        end
    endtask

    // Both words hold the masked patterns after two full frames
    task automatic read_frame_pair(input gc_type_e t, input logic [15:0] mask);
        roll_patterns();
        apply_settings(CONF_A, t, 3'd3);
        wait_busy_falls(2);
        check_eq("o_p1_btn", p1_btn, pat1 & mask);
        check_eq("o_p2_btn", p2_btn, pat2 & mask);
    endtask

    task automatic count_latches(input logic [RATE_W-1:0] r, output int n);
        logic prev;
        apply_settings(CONF_A, GC_NES, r);
        n    = 0;
        prev = bk1_out[1];
        repeat (20000) begin
            @(negedge clk);
            if (bk1_out[1] && !prev) n++;     // Latch rising edge
            prev = bk1_out[1];
        end
    endtask

    task automatic compare_rates();
        int n0;
        int n3;
        count_latches(3'd0, n0);
        count_latches(3'd3, n3);
        if (n0 == 0) begin
            $display("No latch pulses at rate 0");
            test_errs++;
        end
        if (n3 <= 3 * n0) begin
            $display("Rate 3 gave %0d latch pulses and rate 0 gave %0d, too few", n3, n0);
            test_errs++;
        end
    endtask

    task automatic restart_on_change();
        logic cleared;
        read_frame_pair(GC_SNES, 16'hffff);
        wait_busy_rise();
        repeat (100) @(negedge clk);           // Well inside the SNES frame
        roll_patterns();
        apply_settings(CONF_A, GC_NES, 3'd3);
        cleared = 1'b0;
        for (int i = 0; i < 2 && !cleared; i++) begin
            @(negedge clk);
            cleared = (p1_btn == 16'h0) && (p2_btn == 16'h0);
        end
        if (!cleared) begin
            $display("Button words not cleared within 2 cycles of the type change");
            test_errs++;
        end
        wait_busy_falls(2);
        check_eq("o_p1_btn", p1_btn, pat1 & 16'h00ff);
        check_eq("o_p2_btn", p2_btn, pat2 & 16'h00ff);
    endtask

    task automatic conf_b_outputs();
        int cyc;
        roll_patterns();
        apply_settings(CONF_B, GC_NES, 3'd3);
        wait_busy_falls(2);
        check_eq("o_cart_pin30_dir", 16'(pin30_dir), 16'h1);
        check_eq("o_cart_pin31_dir", 16'(pin31_dir), 16'h1);
        check_eq("o_cart_pin31_out", 16'(pin31_out), 16'h0);
        check_eq("o_p1_btn", p1_btn, 16'h0);   // Data held high reads as nothing pressed
        check_eq("o_p2_btn", p2_btn, 16'h0);
        // Pin30 stays low even while the bank1 clock is high
        cyc = 0;
        while (!bk1_out[0] && cyc < FRAME_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!bk1_out[0]) begin
            $display("Timeout at t=%0t, bank1 clock never rose in configuration B", $time);
            test_errs++;
        end
        check_eq("o_cart_pin30_out", 16'(pin30_out), 16'h0);
    endtask

    initial begin
        seed         = 42;
        test_errs    = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        conf_ab      = CONF_A;
        cont_type    = GC_DISABLED;
        rate         = '0;
        pat1         = '0;
        pat2         = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        close_test("reset_state");
        read_frame_pair(GC_NES, 16'h00ff);
        close_test("nes_read");
        read_frame_pair(GC_SNES, 16'hffff);
        read_frame_pair(GC_DB15, 16'h0fff);
        close_test("snes_db15_read");
        compare_rates();
        close_test("rate_select");
        restart_on_change();
        close_test("change_restart");
        conf_b_outputs();
        close_test("conf_b");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: dv/snac_pad_model.sv
// Behavioral model of two serial latch pads on the adapter lines
`timescale 1ns/1ps

module snac_pad_model (
    input  logic        i_lat,     // Latch, loads both pads on its rising edge
    input  logic        i_clk1,    // Player 1 pad clock
    input  logic        i_clk2,    // Player 2 pad clock
    input  logic [15:0] i_pat1,    // Pressed buttons, 1 = pressed
    input  logic [15:0] i_pat2,
    output logic        o_dat1,    // Active low serial data
    output logic        o_dat2
);

    logic [15:0] sh1 = '1;         // Idle pads read as nothing pressed
    logic [15:0] sh2 = '1;

    // Load on latch, shift toward bit 0 on each clock rise, ones fill from the top
    always @(posedge i_lat or posedge i_clk1) begin
        if (i_lat) begin
            sh1 <= ~i_pat1;
        end else begin
            sh1 <= {1'b1, sh1[15:1]};
        end
    end

    always @(posedge i_lat or posedge i_clk2) begin
        if (i_lat) begin
            sh2 <= ~i_pat2;
        end else begin
            sh2 <= {1'b1, sh2[15:1]};
        end
    end

    assign o_dat1 = sh1[0];        // Bit 0 shows as soon as latch loads
    assign o_dat2 = sh2[0];

endmodule

// File: src/snac_top.sv
// SNAC controller top: settings registers, restart on change, strobe, poller and router
`timescale 1ns/1ps

module snac_top import snac_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_conf_ab,
    input  logic [4:0]        i_game_cont_type,
    input  logic [RATE_W-1:0] i_sample_rate,
    output logic [BTN_W-1:0]  o_p1_btn,
    output logic [BTN_W-1:0]  o_p2_btn,
    output logic              o_busy,
    output logic              o_cart_bk0_dir,
    input  logic [3:0]        i_cart_bk0_in,
    output logic [1:0]        o_cart_bk1_out,
    output logic              o_cart_pin30_out,
    output logic              o_cart_pin30_dir,
    input  logic              i_cart_pin30_in,   // Pin30 is never an input here
    output logic              o_cart_pin31_out,
    output logic              o_cart_pin31_dir,
    input  logic              i_cart_pin31_in
);

    logic              conf_r;
    gc_type_e          type_r;
    logic [RATE_W-1:0] rate_r;
    logic              restart;
    logic              stb;
    logic              lat;
    logic              clk_line;
    logic              clk2;
    logic              dat1;
    logic              dat2;

    // Settings registered once, restart pulses on type or rate change
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            conf_r  <= CONF_A;
            type_r  <= GC_DISABLED;
            rate_r  <= '0;
            restart <= 1'b1;                  // Held through reset
        end else begin
            conf_r  <= i_conf_ab;
            type_r  <= gc_type_e'(i_game_cont_type);
            rate_r  <= i_sample_rate;
            restart <= (type_r != i_game_cont_type) || (rate_r != i_sample_rate);
        end
    end

    snac_strobe_gen u_stb (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_restart (restart),
        .i_type    (type_r),
        .i_rate    (rate_r),
        .o_stb     (stb)
    );

    snac_serlatch_poller u_poll (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_restart (restart),
        .i_type    (type_r),
        .i_stb     (stb),
        .i_dat1    (dat1),
        .i_dat2    (dat2),
        .o_lat     (lat),
        .o_clk     (clk_line),
        .o_clk2    (clk2),
        .o_busy    (o_busy),
        .o_p1_btn  (o_p1_btn),
        .o_p2_btn  (o_p2_btn)
    );

    snac_pin_router u_route (
        .i_conf      (conf_r),
        .i_lat       (lat),
        .i_clk_line  (clk_line),
        .i_clk2      (clk2),
        .o_dat1      (dat1),
        .o_dat2      (dat2),
        .i_bk0_in    (i_cart_bk0_in),
        .o_bk0_dir   (o_cart_bk0_dir),
        .o_bk1_out   (o_cart_bk1_out),
        .o_pin30_out (o_cart_pin30_out),
        .o_pin30_dir (o_cart_pin30_dir),
        .i_pin31_in  (i_cart_pin31_in),
        .o_pin31_out (o_cart_pin31_out),
        .o_pin31_dir (o_cart_pin31_dir)
    );

endmodule

// File: src/snac_pin_router.sv
// Cartridge pin routing and directions for adapter configurations A and B
`timescale 1ns/1ps

module snac_pin_router import snac_pkg::*; (
    input  logic       i_conf,        // CONF_A or CONF_B
    input  logic       i_lat,
    input  logic       i_clk_line,
    input  logic       i_clk2,
    output logic       o_dat1,
    output logic       o_dat2,
    input  logic [3:0] i_bk0_in,      // Bank0 bits 7:4
    output logic       o_bk0_dir,
    output logic [1:0] o_bk1_out,     // Bank1 bits 7:6
    output logic       o_pin30_out,
    output logic       o_pin30_dir,
    input  logic       i_pin31_in,    // Reserved for crossed-cable alternate data
    output logic       o_pin31_out,
    output logic       o_pin31_dir
);

    always_comb begin
        o_bk0_dir = 1'b0;                     // Bank0 always input
        o_bk1_out = {i_lat, i_clk_line};      // Bit 7 latch, bit 6 clock
        if (i_conf == CONF_A) begin
            o_pin30_dir = 1'b1;
            o_pin30_out = i_clk2;             // Second clock on IO5
            o_pin31_dir = 1'b0;
            o_pin31_out = 1'b0;
            o_dat1      = i_bk0_in[0];        // Bank0 bit 4
            o_dat2      = i_bk0_in[1];        // Bank0 bit 5
        end else begin
            o_pin30_dir = 1'b1;
            o_pin30_out = 1'b0;
            o_pin31_dir = 1'b1;
            o_pin31_out = 1'b0;
            o_dat1      = 1'b1;               // Idle high, nothing pressed
            o_dat2      = 1'b1;
        end
    end

endmodule

// File: src/snac_serlatch_poller.sv
// Serial latch poll sequencer: latch pulse, bit clocking and two-player capture
`timescale 1ns/1ps

module snac_serlatch_poller import snac_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_restart,
    input  gc_type_e         i_type,
    input  logic             i_stb,       // Advance one state per strobe
    input  logic             i_dat1,      // Player 1 data, active low
    input  logic             i_dat2,      // Player 2 data, active low
    output logic             o_lat,
    output logic             o_clk,
    output logic             o_clk2,
    output logic             o_busy,
    output logic [BTN_W-1:0] o_p1_btn,
    output logic [BTN_W-1:0] o_p2_btn
);

    poll_state_e          state;
    logic [BIT_IDX_W-1:0] bit_cnt;        // Bit position k within the frame
    logic [BTN_W-1:0]     sr1;
    logic [BTN_W-1:0]     sr2;
    logic                 clk_q;
    logic                 active;
    logic                 last_bit;

    assign active   = gc_active(i_type);
    assign last_bit = ({1'b0, bit_cnt} == frame_bits(i_type) - 1'b1);

    // Both pads share one clock waveform
    assign o_clk  = clk_q;
    assign o_clk2 = clk_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            o_lat    <= 1'b0;
            clk_q    <= 1'b0;
            o_busy   <= 1'b0;
            o_p1_btn <= '0;
            o_p2_btn <= '0;
        end else if (i_restart || !active) begin
            // Setting change or disabled pad, park everything
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            o_lat    <= 1'b0;
            clk_q    <= 1'b0;
            o_busy   <= 1'b0;
            o_p1_btn <= '0;
            o_p2_btn <= '0;
        end else if (i_stb) begin
            case (state)
                ST_IDLE: begin
                    state   <= ST_LATCH_HI;
                    o_lat   <= 1'b1;           // Pads load their buttons
                    o_busy  <= 1'b1;
                    bit_cnt <= '0;
                end
                ST_LATCH_HI: begin
                    state <= ST_LATCH_LO;
                    o_lat <= 1'b0;
                end
                ST_LATCH_LO: begin
                    state <= ST_CLK_LO;
                    clk_q <= 1'b0;
                end
                ST_CLK_LO: begin
                    state <= ST_CLK_HI;        // Data sampled on this strobe
                    clk_q <= 1'b1;             // Rising edge shifts the pads
                end
                ST_CLK_HI: begin
                    clk_q <= 1'b0;
                    if (last_bit) begin
                        // Publish both words together
                        state    <= ST_IDLE;
                        o_busy   <= 1'b0;
                        o_p1_btn <= sr1;
                        o_p2_btn <= sr2;
                    end else begin
                        state   <= ST_CLK_LO;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    o_lat <= 1'b0;
                    clk_q <= 1'b0;
                    o_busy <= 1'b0;
                end
            endcase
        end
    end

    // Capture registers, cleared at each frame start so unused upper bits read 0
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            if (state == ST_IDLE) begin
                sr1 <= '0;
                sr2 <= '0;
            end else if (state == ST_CLK_LO) begin
                sr1[bit_cnt] <= ~i_dat1;       // Pressed reads as 1
                sr2[bit_cnt] <= ~i_dat2;
            end
        end
    end

endmodule

// File: src/snac_strobe_gen.sv
// Fractional strobe generator with per-rate step selection and phase accumulator
`timescale 1ns/1ps

module snac_strobe_gen import snac_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_restart,   // Sync clear of the accumulator
    input  gc_type_e          i_type,
    input  logic [RATE_W-1:0] i_rate,
    output logic              o_stb        // One-cycle pulse on accumulator carry
);

    logic [STEP_W-1:0] step_sel;
    logic [STEP_W-1:0] step_r;
    logic [STEP_W-1:0] acc;

    // Step lookup, zero step stops the strobe entirely
    always_comb begin
        if (!gc_active(i_type)) begin
            step_sel = '0;
        end else if (int'(i_rate) < NUM_RATES) begin
            step_sel = rate_steps[i_rate];
        end else begin
            step_sel = rate_steps[0];       // Out of range falls back to compat rate
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            step_r <= '0;
            acc    <= '0;
            o_stb  <= 1'b0;
        end else begin
            step_r <= step_sel;             // Registered to keep the adder path short
            if (i_restart) begin
                acc   <= '0;
                o_stb <= 1'b0;
            end else begin
                // Carry out of the add is the strobe
                {o_stb, acc} <= {1'b0, acc} + {1'b0, step_r};
            end
        end
    end

endmodule

// File: src/snac_pkg.sv
// SNAC shared definitions: clock, rate step table, controller and poll state enums, widths
package snac_pkg;

    localparam int MASTER_CLK_FREQ = 50_000_000;   // Core clock in Hz
    localparam int STEP_W          = 32;           // Phase accumulator width
    localparam int RATE_W          = 3;            // Sample rate select width
    localparam int NUM_RATES       = 7;
    localparam int BTN_W           = 16;           // Button word per player
    localparam int BIT_IDX_W       = $clog2(BTN_W);

    // Bits clocked out per frame for each serial latch pad
    localparam logic [BIT_IDX_W:0] NES_BITS  = 8;
    localparam logic [BIT_IDX_W:0] DB15_BITS = 12;
    localparam logic [BIT_IDX_W:0] SNES_BITS = 16;

    // Adapter configuration select
    localparam logic CONF_A = 1'b0;
    localparam logic CONF_B = 1'b1;

    typedef enum logic [4:0] {
        GC_DISABLED = 5'd0,
        GC_DB15     = 5'd1,
        GC_NES      = 5'd2,
        GC_SNES     = 5'd3
    } gc_type_e;                                    // Unlisted codes act as disabled

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LATCH_HI,
        ST_LATCH_LO,
        ST_CLK_LO,
        ST_CLK_HI
    } poll_state_e;

    // Sequencer runs at twice the poll rate, so one full turn per half period
    function automatic logic [STEP_W-1:0] calc_step(input longint unsigned hz);
        logic [63:0] full;
        full = ((64'd1 << STEP_W) * 64'd2 * hz) / 64'(MASTER_CLK_FREQ);
        return full[STEP_W-1:0];
    endfunction

    localparam logic [STEP_W-1:0] rate_steps [NUM_RATES] = '{
        calc_step(100_000),     // 0 compat
        calc_step(200_000),     // 1 normal
        calc_step(400_000),     // 2 fast
        calc_step(1_000_000),   // 3 very fast
        calc_step(20_000),      // 4 slow SNES
        calc_step(1_080),       // 5 near 60 Hz frames
        calc_step(2_160)        // 6 near 120 Hz frames
    };

    function automatic logic gc_active(input gc_type_e t);
        return (t == GC_DB15) || (t == GC_NES) || (t == GC_SNES);
    endfunction

    function automatic logic [BIT_IDX_W:0] frame_bits(input gc_type_e t);
        case (t)
            GC_NES:  return NES_BITS;
            GC_DB15: return DB15_BITS;
            GC_SNES: return SNES_BITS;
            default: return '0;
        endcase
    endfunction

endpackage
